/* decode_pkg.sv */
package decode_pkg;

    ////////////////////
    // sizes
    localparam int packet_bytes = 16;                  // one fetch packet
    localparam int packet_width = packet_bytes * 8;    // byte 0 in the top bits
    localparam int max_prefixes = 3;
    localparam int eip_width    = 32;
    localparam int len_width    = 5;                   // longest legal form is 14 bytes

    typedef logic [len_width-1:0] len_t;

    ////////////////////
    // prefix bytes
    localparam logic [7:0] pfx_rep    = 8'hf3;
    localparam logic [7:0] pfx_opsize = 8'h66;
    localparam logic [7:0] pfx_es     = 8'h26;
    localparam logic [7:0] pfx_cs     = 8'h2e;
    localparam logic [7:0] pfx_ss     = 8'h36;
    localparam logic [7:0] pfx_ds     = 8'h3e;
    localparam logic [7:0] pfx_fs     = 8'h64;
    localparam logic [7:0] pfx_gs     = 8'h65;

    // segment override, none when no seg prefix seen
    typedef enum logic [2:0] {
        seg_none = 3'd0,
        seg_es   = 3'd1,
        seg_cs   = 3'd2,
        seg_ss   = 3'd3,
        seg_ds   = 3'd4,
        seg_fs   = 3'd5,
        seg_gs   = 3'd6
    } seg_sel_t;

    // imm size code, z is 16 or 32 by opsize
    typedef enum logic [1:0] {
        imm_none = 2'd0,
        imm_byte = 2'd1,
        imm_z    = 2'd2
    } imm_size_t;

    ////////////////////
    // records
    typedef struct packed {
        logic       rep;
        logic       opsize;
        seg_sel_t   seg;        // last override wins
        logic [1:0] count;      // leading prefixes, 0..3
        logic       is_seg;
        logic [2:0] spare;
    } prefix_info_t;

    typedef struct packed {
        logic       has_modrm;
        imm_size_t  imm_size;
        logic       illegal;
        logic [1:0] spare;
    } op_class_t;

    typedef struct packed {
        logic [eip_width-1:0] eip;      // eip of this instr, pre-advance
        logic [len_width-1:0] length;
        prefix_info_t         info;
        logic [7:0]           opcode;
        op_class_t            op_class;
        logic [7:0]           modrm;    // zero if none
        logic                 has_sib;
        logic [31:0]          disp;     // sign extended
        logic [31:0]          imm;      // sign extended
    } decoded_t;

    // seg code of a byte, seg_none if not a seg prefix
    function automatic seg_sel_t seg_of(input logic [7:0] b);
        case (b)
            pfx_es:  return seg_es;
            pfx_cs:  return seg_cs;
            pfx_ss:  return seg_ss;
            pfx_ds:  return seg_ds;
            pfx_fs:  return seg_fs;
            pfx_gs:  return seg_gs;
            default: return seg_none;
        endcase
    endfunction

    function automatic logic is_prefix(input logic [7:0] b);
        return (b == pfx_rep) || (b == pfx_opsize) || (seg_of(b) != seg_none);
    endfunction

endpackage

/* prefix_decode.sv */
`timescale 1ns/10ps

module prefix_decode (
    input  logic [decode_pkg::max_prefixes*8-1:0] bytes,  // first packet bytes, byte 0 on top
    output decode_pkg::prefix_info_t              info
);

    logic [7:0]           cur;      // byte under test
    logic                 run;      // still inside the leading prefix run
    decode_pkg::seg_sel_t seg_cur;  // seg code of cur

    ////////////////////
    // scan the leading run
    always_comb begin
        info    = '0;
        run     = 1'b1;
        cur     = 8'h00;
        seg_cur = decode_pkg::seg_none;

        for (int i = 0; i < decode_pkg::max_prefixes; i++) begin
            cur     = bytes[(decode_pkg::max_prefixes-1-i)*8 +: 8];
            seg_cur = decode_pkg::seg_of(cur);
            run     = run && decode_pkg::is_prefix(cur);   // first non-prefix ends the run

            if (run) begin
                info.count = info.count + 2'd1;

                // flags are sticky across the run
                if (cur == decode_pkg::pfx_rep)
                    info.rep = 1'b1;
                if (cur == decode_pkg::pfx_opsize)
                    info.opsize = 1'b1;

                // later override replaces an earlier one
                if (seg_cur != decode_pkg::seg_none) begin
                    info.seg    = seg_cur;
                    info.is_seg = 1'b1;
                end
            end
        end
    end

endmodule

/* opcode_decode.sv */
`timescale 1ns/10ps

module opcode_decode (
    input  logic [7:0]            opcode,
    output decode_pkg::op_class_t op_class
);

    logic [2:0] low;        // opcode[2:0], picks the form in the alu block
    logic       stray_pfx;  // a prefix byte sitting in the opcode slot

    assign low       = opcode[2:0];
    assign stray_pfx = decode_pkg::is_prefix(opcode);

    ////////////////////
    // opcode table
    always_comb begin
        op_class = '0;

        casez (opcode)
            // 00-3f alu block, r/m forms then al/eax imm forms
            8'b00??_????: begin
                op_class.illegal = stray_pfx;   // es/cs/ss/ds past the third prefix
                if (low <= 3'd3)
                    op_class.has_modrm = 1'b1;
                else if (low == 3'd4)
                    op_class.imm_size = decode_pkg::imm_byte;
                else if (low == 3'd5)
                    op_class.imm_size = decode_pkg::imm_z;
            end

            8'b010?_????: op_class.illegal = 1'b0;  // inc/dec/push/pop reg

            // group 1 alu with imm
            8'h80, 8'h83: begin
                op_class.has_modrm = 1'b1;
                op_class.imm_size  = decode_pkg::imm_byte;
            end
            8'h81: begin
                op_class.has_modrm = 1'b1;
                op_class.imm_size  = decode_pkg::imm_z;
            end

            8'b1000_10??: op_class.has_modrm = 1'b1;   // mov 88-8b

            8'h90: op_class.illegal = 1'b0;            // nop

            8'b1011_0???: op_class.imm_size = decode_pkg::imm_byte;  // mov r8, imm8
            8'b1011_1???: op_class.imm_size = decode_pkg::imm_z;     // mov r32, imm

            8'hc3: op_class.illegal = 1'b0;            // ret
            8'he8: op_class.imm_size = decode_pkg::imm_z;     // call rel
            8'heb: op_class.imm_size = decode_pkg::imm_byte;  // jmp rel8

            // not in the subset, incl 64/65/66/f3 past the third prefix
            default: op_class.illegal = 1'b1;
        endcase
    end

endmodule

/* length_decode.sv */
`timescale 1ns/10ps

module length_decode (
    input  logic [decode_pkg::packet_width-1:0] packet,
    input  decode_pkg::prefix_info_t            info,
    output decode_pkg::op_class_t               op_class,   // from the opcode table below
    output logic [7:0]                          opcode,
    output logic [7:0]                          modrm,
    output logic                                has_sib,
    output logic [31:0]                         disp,
    output logic [31:0]                         imm,
    output logic [decode_pkg::len_width-1:0]    length
);

    logic [7:0] pb [decode_pkg::packet_bytes];  // byte view, pb[0] is the first byte
    logic [3:0] op_idx;                         // opcode position = prefix count
    logic [3:0] disp_idx;
    logic [3:0] imm_idx;
    logic [7:0] sib;
    logic [1:0] md;                             // modrm.mod
    logic [2:0] rm;                             // modrm.rm
    logic [2:0] disp_len;                       // 0, 1 or 4
    logic [2:0] imm_len;                        // 0, 1, 2 or 4

    // little endian bytes to a sign extended value
    function automatic logic [31:0] le_sext(input logic [31:0] raw, input logic [2:0] nbytes);
        case (nbytes)
            3'd1:    return {{24{raw[7]}}, raw[7:0]};
            3'd2:    return {{16{raw[15]}}, raw[15:0]};
            3'd4:    return raw;
            default: return 32'h0;
        endcase
    endfunction

    ////////////////////
    // opcode and modrm
    always_comb begin
        for (int i = 0; i < decode_pkg::packet_bytes; i++)
            pb[i] = packet[(decode_pkg::packet_bytes-1-i)*8 +: 8];
    end

    assign op_idx = {2'b00, info.count};
    assign opcode = pb[op_idx];

    opcode_decode opcode0 (
        .opcode   (opcode),
        .op_class (op_class)
    );

    assign modrm   = op_class.has_modrm ? pb[op_idx + 4'd1] : 8'h00;
    assign md      = modrm[7:6];
    assign rm      = modrm[2:0];
    assign has_sib = op_class.has_modrm && (md != 2'b11) && (rm == 3'd4);
    assign sib     = has_sib ? pb[op_idx + 4'd2] : 8'h00;

    ////////////////////
    // field sizes
    always_comb begin
        disp_len = 3'd0;
        if (op_class.has_modrm) begin
            case (md)
                2'b00: begin
                    // disp32 only form, or sib with base 5
                    if (rm == 3'd5 || (has_sib && sib[2:0] == 3'd5))
                        disp_len = 3'd4;
                end
                2'b01:   disp_len = 3'd1;
                2'b10:   disp_len = 3'd4;
                default: disp_len = 3'd0;   // register operand
            endcase
        end
    end

    always_comb begin
        case (op_class.imm_size)
            decode_pkg::imm_byte: imm_len = 3'd1;
            decode_pkg::imm_z:    imm_len = info.opsize ? 3'd2 : 3'd4;
            default:              imm_len = 3'd0;
        endcase
    end

    ////////////////////
    // extraction
    assign disp_idx = op_idx + 4'd1 + {3'b000, op_class.has_modrm} + {3'b000, has_sib};
    assign imm_idx  = disp_idx + {1'b0, disp_len};

    assign disp = le_sext({pb[disp_idx + 4'd3], pb[disp_idx + 4'd2],
                           pb[disp_idx + 4'd1], pb[disp_idx]}, disp_len);
    assign imm  = le_sext({pb[imm_idx + 4'd3], pb[imm_idx + 4'd2],
                           pb[imm_idx + 4'd1], pb[imm_idx]}, imm_len);

    // prefixes + opcode + modrm + sib + disp + imm, max 14
    assign length = decode_pkg::len_t'(op_idx)
                  + decode_pkg::len_t'(1)
                  + decode_pkg::len_t'(op_class.has_modrm)
                  + decode_pkg::len_t'(has_sib)
                  + decode_pkg::len_t'(disp_len)
                  + decode_pkg::len_t'(imm_len);

endmodule

/* eip_track.sv */
`timescale 1ns/10ps

module eip_track (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             accept,     // packet taken this edge
    input  logic [decode_pkg::len_width-1:0] length,
    input  logic                             is_init,
    input  logic [decode_pkg::eip_width-1:0] init_eip,
    input  logic                             is_resteer,
    input  logic [decode_pkg::eip_width-1:0] wb_eip,
    input  logic                             is_br,
    input  logic [decode_pkg::eip_width-1:0] bp_eip,
    output logic [decode_pkg::eip_width-1:0] eip
);

    logic                             cf_any;     // some redirect this cycle
    logic [decode_pkg::eip_width-1:0] cf_target;  // winning redirect target
    logic [decode_pkg::eip_width-1:0] seq_eip;    // eip + length

    assign cf_any = is_init | is_resteer | is_br;

    // init over resteer over predicted branch
    always_comb begin
        if (is_init)
            cf_target = init_eip;
        else if (is_resteer)
            cf_target = wb_eip;
        else
            cf_target = bp_eip;
    end

    assign seq_eip = eip + {{(decode_pkg::eip_width-decode_pkg::len_width){1'b0}}, length};

    ////////////////////
    // eip register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eip <= '0;
        end else if (cf_any) begin
            eip <= cf_target;       // taken even under stall
        end else if (accept) begin
            eip <= seq_eip;
        end
    end

endmodule

/* decode_top.sv */
`timescale 1ns/10ps

module decode_top (
    input  logic                                clk,
    input  logic                                rst_n,

    // fetch side
    input  logic                                valid_in,
    input  logic [decode_pkg::packet_width-1:0] packet_in,   // byte 0 in top bits

    // downstream
    input  logic                                stall,

    // control flow redirects
    input  logic                                is_init,
    input  logic [decode_pkg::eip_width-1:0]    init_eip,
    input  logic                                is_resteer,
    input  logic [decode_pkg::eip_width-1:0]    wb_eip,
    input  logic                                is_br,
    input  logic [decode_pkg::eip_width-1:0]    bp_eip,

    // to the next stage
    output logic                                valid_out,
    output decode_pkg::decoded_t                decoded_out
);

    decode_pkg::prefix_info_t         info;
    decode_pkg::op_class_t            op_class;
    logic [7:0]                       opcode;
    logic [7:0]                       modrm;
    logic                             has_sib;
    logic [31:0]                      disp;
    logic [31:0]                      imm;
    logic [decode_pkg::len_width-1:0] length;
    logic [decode_pkg::eip_width-1:0] eip;       // eip of the packet in front of us
    logic                             cf_flush;  // any redirect, drops this packet
    logic                             accept;
    decode_pkg::decoded_t             rec;       // record before the output reg

    assign cf_flush = is_init | is_resteer | is_br;
    assign accept   = valid_in & ~stall & ~cf_flush;

    ////////////////////
    // decode
    prefix_decode prefix0 (
        .bytes (packet_in[decode_pkg::packet_width-1 -: decode_pkg::max_prefixes*8]),
        .info  (info)
    );

    length_decode len0 (
        .packet   (packet_in),
        .info     (info),
        .op_class (op_class),
        .opcode   (opcode),
        .modrm    (modrm),
        .has_sib  (has_sib),
        .disp     (disp),
        .imm      (imm),
        .length   (length)
    );

    eip_track eip0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .accept     (accept),
        .length     (length),
        .is_init    (is_init),
        .init_eip   (init_eip),
        .is_resteer (is_resteer),
        .wb_eip     (wb_eip),
        .is_br      (is_br),
        .bp_eip     (bp_eip),
        .eip        (eip)
    );

    always_comb begin
        rec          = '0;
        rec.eip      = eip;         // value before this accept advances it
        rec.length   = length;
        rec.info     = info;
        rec.opcode   = opcode;
        rec.op_class = op_class;
        rec.modrm    = modrm;
        rec.has_sib  = has_sib;
        rec.disp     = disp;
        rec.imm      = imm;
    end

    ////////////////////
    // output register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (cf_flush) begin
            valid_out <= 1'b0;      // redirect kills what is in flight
        end else if (!stall) begin
            valid_out <= accept;
        end
    end

    // payload only moves on accept, so it holds under stall
    always_ff @(posedge clk) begin
        if (accept)
            decoded_out <= rec;
    end

endmodule

/* tb_decode_top.sv */
`timescale 1ns/10ps

module tb_decode_top;

    localparam int reset_cycles = 8;
    localparam int num_cycles   = 400;                  // random cycles after the directed start
    localparam int sched_cycles = reset_cycles + 2 + num_cycles + 10;
    localparam int cycle_limit  = 2 * sched_cycles + 100;

    logic                                clk;
    logic                                rst_n;
    logic                                valid_in;
    logic [decode_pkg::packet_width-1:0] packet_in;
    logic                                stall;
    logic                                is_init;
    logic [31:0]                         init_eip;
    logic                                is_resteer;
    logic [31:0]                         wb_eip;
    logic                                is_br;
    logic [31:0]                         bp_eip;
    logic                                valid_out;
    decode_pkg::decoded_t                decoded_out;

    decode_pkg::decoded_t exp_q [$];    // records in flight with the output reg in front
    decode_pkg::decoded_t exp_rec;
    decode_pkg::decoded_t last_rec;
    logic [15:0]          lfsr_q;
    logic [31:0]          model_eip;
    logic [31:0]          first_eip;
    logic                 hold_pkt;     // fetch must repeat the stalled packet
    logic                 exp_valid;    // model of valid_out
    logic                 last_hold;    // previous edge was a plain stall
    logic                 first_seen;
    logic                 cf_now;
    int                   errors;
    int                   n_checked;
    int                   cycles;

    decode_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_in    (valid_in),
        .packet_in   (packet_in),
        .stall       (stall),
        .is_init     (is_init),
        .init_eip    (init_eip),
        .is_resteer  (is_resteer),
        .wb_eip      (wb_eip),
        .is_br       (is_br),
        .bp_eip      (bp_eip),
        .valid_out   (valid_out),
        .decoded_out (decoded_out)
    );

    always #10 clk = ~clk;

    ////////////////////
    // random source
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16 14 13 11
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};  // one step per bit
        end
        return v;
    endfunction

    ////////////////////
    // reference model
    function automatic logic is_pfx_byte(input logic [7:0] x);
        return x == 8'hf3 || x == 8'h66 || x == 8'h26 || x == 8'h2e ||
               x == 8'h36 || x == 8'h3e || x == 8'h64 || x == 8'h65;
    endfunction

    function automatic decode_pkg::seg_sel_t seg_code(input logic [7:0] x);
        case (x)
            8'h26:   return decode_pkg::seg_es;
            8'h2e:   return decode_pkg::seg_cs;
            8'h36:   return decode_pkg::seg_ss;
            8'h3e:   return decode_pkg::seg_ds;
            8'h64:   return decode_pkg::seg_fs;
            8'h65:   return decode_pkg::seg_gs;
            default: return decode_pkg::seg_none;
        endcase
    endfunction

    function automatic decode_pkg::op_class_t class_of(input logic [7:0] op);
        decode_pkg::op_class_t c;
        c = '0;
        if (is_pfx_byte(op))
            c.illegal = 1'b1;                   // stray fourth prefix
        else if (op < 8'h40) begin
            case (op[2:0])
                3'd0, 3'd1, 3'd2, 3'd3: c.has_modrm = 1'b1;
                3'd4:    c.imm_size = decode_pkg::imm_byte;
                3'd5:    c.imm_size = decode_pkg::imm_z;
                default: c.illegal = 1'b0;      // low 6 and 7 bare
            endcase
        end else if (op < 8'h60)
            c.illegal = 1'b0;
        else if (op == 8'h80 || op == 8'h83) begin
            c.has_modrm = 1'b1;
            c.imm_size  = decode_pkg::imm_byte;
        end else if (op == 8'h81) begin
            c.has_modrm = 1'b1;
            c.imm_size  = decode_pkg::imm_z;
        end else if (op >= 8'h88 && op <= 8'h8b)
            c.has_modrm = 1'b1;
        else if (op == 8'h90 || op == 8'hc3)
            c.illegal = 1'b0;
        else if ((op >= 8'hb0 && op <= 8'hb7) || op == 8'heb)
            c.imm_size = decode_pkg::imm_byte;
        else if ((op >= 8'hb8 && op <= 8'hbf) || op == 8'he8)
            c.imm_size = decode_pkg::imm_z;
        else
            c.illegal = 1'b1;
        return c;
    endfunction

    function automatic logic [7:0] byte_at(input logic [127:0] pkt, input int pos);
        return pkt[127-8*pos -: 8];     // byte 0 on top
    endfunction

    // little endian field with sign extension
    function automatic logic [31:0] read_le(input logic [127:0] pkt, input int pos, input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = v | ({24'd0, byte_at(pkt, pos + k)} << (8 * k));
        if (n == 1)
            v = {{24{v[7]}}, v[7:0]};
        else if (n == 2)
            v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    function automatic decode_pkg::decoded_t ref_decode(input logic [127:0] pkt,
                                                        input logic [31:0] eip);
        decode_pkg::decoded_t r;
        logic [7:0] b;
        logic [7:0] sib;
        logic       stop;
        int         cnt;
        int         idx;
        int         dlen;
        int         ilen;
        r    = '0;
        stop = 1'b0;
        cnt  = 0;
        sib  = 8'h00;
        r.eip = eip;
        for (int i = 0; i < 3; i++) begin
            b = byte_at(pkt, i);
            if (!stop && is_pfx_byte(b)) begin
                cnt++;
                if (b == 8'hf3) r.info.rep = 1'b1;
                if (b == 8'h66) r.info.opsize = 1'b1;
                if (seg_code(b) != decode_pkg::seg_none) begin
                    r.info.seg    = seg_code(b);    // last one wins
                    r.info.is_seg = 1'b1;
                end
            end else
                stop = 1'b1;
        end
        r.info.count = 2'(cnt);
        r.opcode     = byte_at(pkt, cnt);
        r.op_class   = class_of(r.opcode);
        idx          = cnt + 1;
        dlen         = 0;
        if (r.op_class.has_modrm) begin
            r.modrm   = byte_at(pkt, idx);
            idx++;
            r.has_sib = (r.modrm[7:6] != 2'b11) && (r.modrm[2:0] == 3'd4);
            if (r.has_sib) begin
                sib = byte_at(pkt, idx);
                idx++;
            end
            if (r.modrm[7:6] == 2'b00 && (r.modrm[2:0] == 3'd5 || (r.has_sib && sib[2:0] == 3'd5)))
                dlen = 4;
            else if (r.modrm[7:6] == 2'b01)
                dlen = 1;
            else if (r.modrm[7:6] == 2'b10)
                dlen = 4;
        end
        r.disp = read_le(pkt, idx, dlen);
        idx    = idx + dlen;
        case (r.op_class.imm_size)
            decode_pkg::imm_byte: ilen = 1;
            decode_pkg::imm_z:    ilen = r.info.opsize ? 2 : 4;
            default:              ilen = 0;
        endcase
        r.imm    = read_le(pkt, idx, ilen);
        r.length = 5'(idx + ilen);
        return r;
    endfunction

    ////////////////////
    // stimulus helpers
    function automatic logic [7:0] pick_prefix(input logic [2:0] sel);
        case (sel)
            3'd0:    return 8'hf3;
            3'd1:    return 8'h66;
            3'd2:    return 8'h26;
            3'd3:    return 8'h2e;
            3'd4:    return 8'h36;
            3'd5:    return 8'h3e;
            3'd6:    return 8'h64;
            default: return 8'h65;
        endcase
    endfunction

    function automatic logic [7:0] pick_opcode();
        logic [31:0] r;
        logic [31:0] s;
        r = rand_bits(3);
        s = rand_bits(8);
        case (r[2:0])
            3'd0: return s[7:0];                  // any byte at all
            3'd1: return {2'b00, s[5:0]};         // alu block
            3'd2: return {6'b100000, s[1:0]};     // 80-83 with 82 illegal
            3'd3: return {6'b100010, s[1:0]};     // mov 88-8b
            3'd4: return {4'hb, s[3:0]};          // mov imm
            3'd5: begin
                case (s[1:0])
                    2'd0:    return 8'h90;
                    2'd1:    return 8'hc3;
                    2'd2:    return 8'he8;
                    default: return 8'heb;
                endcase
            end
            3'd6: return {3'b010, s[4:0]};
            default: return 8'h81;
        endcase
    endfunction

    function automatic logic [127:0] make_packet();
        logic [127:0] p;
        logic [31:0]  r;
        int           npfx;
        for (int i = 0; i < 16; i++) begin
            r = rand_bits(8);
            p[127-8*i -: 8] = r[7:0];   // filler and modrm sib disp imm bytes
        end
        r    = rand_bits(2);
        npfx = int'(r);
        if (npfx == 3 && rand_bits(2) == 32'd0)
            npfx = 4;                   // prefix lands in opcode slot
        for (int i = 0; i < npfx; i++) begin
            r = rand_bits(3);
            p[127-8*i -: 8] = pick_prefix(r[2:0]);
        end
        if (npfx < 4)
            p[127-8*npfx -: 8] = pick_opcode();
        return p;
    endfunction

    task automatic record_accept();
        decode_pkg::decoded_t e;
        e = ref_decode(packet_in, model_eip);
        exp_q.push_back(e);
        model_eip = model_eip + {27'd0, e.length};
    endtask

    task automatic drive_random();
        logic redirect;
        redirect   = (rand_bits(4) == 32'd0);
        stall      = (rand_bits(3) == 32'd0);
        is_init    = redirect && (rand_bits(1) != 32'd0);
        is_resteer = redirect && (rand_bits(1) != 32'd0);
        is_br      = redirect && (rand_bits(1) != 32'd0);
        if (redirect && !is_init && !is_resteer)
            is_br = 1'b1;
        init_eip = rand_bits(32);
        wb_eip   = rand_bits(32);
        bp_eip   = rand_bits(32);
        if (!hold_pkt) begin
            valid_in  = (rand_bits(3) != 32'd0);
            packet_in = make_packet();
        end
        hold_pkt = valid_in && stall && !redirect;
        if (redirect)
            model_eip = is_init ? init_eip : (is_resteer ? wb_eip : bp_eip);
        else if (valid_in && !stall)
            record_accept();
    endtask

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_record(input decode_pkg::decoded_t got, input decode_pkg::decoded_t exp);
        check_field("eip", got.eip, exp.eip);
        check_field("length", 32'(got.length), 32'(exp.length));
        check_field("rep", 32'(got.info.rep), 32'(exp.info.rep));
        check_field("opsize", 32'(got.info.opsize), 32'(exp.info.opsize));
        check_field("seg", 32'(got.info.seg), 32'(exp.info.seg));
        check_field("count", 32'(got.info.count), 32'(exp.info.count));
        check_field("is_seg", 32'(got.info.is_seg), 32'(exp.info.is_seg));
        check_field("info spare", 32'(got.info.spare), 32'(exp.info.spare));
        check_field("opcode", 32'(got.opcode), 32'(exp.opcode));
        check_field("op_class", 32'(got.op_class), 32'(exp.op_class));
        check_field("modrm", 32'(got.modrm), 32'(exp.modrm));
        check_field("has_sib", 32'(got.has_sib), 32'(exp.has_sib));
        check_field("disp", got.disp, exp.disp);
        check_field("imm", got.imm, exp.imm);
    endtask

    ////////////////////
    // compare at the rising edge before the update
    always @(posedge clk) begin
        if (rst_n) begin
            cf_now = is_init | is_resteer | is_br;
            if (valid_out !== exp_valid) begin
                $display("ERROR valid_out got %h expected %h", valid_out, exp_valid);
                errors++;
            end
            if (last_hold) begin
                if (decoded_out !== last_rec) begin
                    $display("ERROR decoded_out got %h expected %h", decoded_out, last_rec);
                    errors++;
                end
            end
            if (valid_out && !first_seen) begin
                first_seen = 1'b1;
                check_field("first eip", decoded_out.eip, first_eip);
            end
            if (valid_out && !stall) begin
                if (exp_q.size() == 0) begin
                    $display("record on valid_out with nothing expected");
                    errors++;
                end else begin
                    exp_rec = exp_q.pop_front();
                    check_record(decoded_out, exp_rec);
                    n_checked++;
                end
            end else if (valid_out && stall && cf_now && exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();    // killed in the output reg
            end
            last_rec   = decoded_out;
            last_hold  = stall && !cf_now;
            // cleared by a redirect and held by a stall
            if (cf_now)
                exp_valid = 1'b0;
            else if (!stall)
                exp_valid = valid_in;   // accept shows one cycle later
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, run still going after %0d cycles", cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////
    // main sequence
    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        valid_in   = 1'b0;
        packet_in  = '0;
        stall      = 1'b0;
        is_init    = 1'b0;
        init_eip   = '0;
        is_resteer = 1'b0;
        wb_eip     = '0;
        is_br      = 1'b0;
        bp_eip     = '0;
        lfsr_q     = 16'd43670;
        model_eip  = '0;
        first_eip  = '0;
        hold_pkt   = 1'b0;
        exp_valid  = 1'b0;
        last_rec   = '0;
        last_hold  = 1'b0;
        first_seen = 1'b0;
        errors     = 0;
        n_checked  = 0;
        cycles     = 0;

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_field("valid_out after reset", 32'(valid_out), 32'd0);
        // all three redirects at once so init wins and the packet drops
        is_init    = 1'b1;
        is_resteer = 1'b1;
        is_br      = 1'b1;
        init_eip   = rand_bits(32);
        wb_eip     = rand_bits(32);
        bp_eip     = rand_bits(32);
        first_eip  = init_eip;
        model_eip  = init_eip;
        valid_in   = 1'b1;
        packet_in  = make_packet();

        @(negedge clk);
        is_init    = 1'b0;
        is_resteer = 1'b0;
        is_br      = 1'b0;
        packet_in  = make_packet();
        record_accept();                // first record at init_eip

        repeat (num_cycles) begin
            @(negedge clk);
            drive_random();
        end

        // drain with the pipe open
        @(negedge clk);
        stall      = 1'b0;
        valid_in   = 1'b0;
        is_init    = 1'b0;
        is_resteer = 1'b0;
        is_br      = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);

        if (n_checked == 0) begin
            $display("no records were compared");
            errors++;
        end
        $display("records checked %0d, errors %0d", n_checked, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* flist.f */
decode_pkg.sv
prefix_decode.sv
opcode_decode.sv
length_decode.sv
eip_track.sv
decode_top.sv
tb_decode_top.sv

/* run.sh */
#!/bin/sh
# build and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_decode_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_decode_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
echo "pass message not found"
exit 1
